// ==== div_array.f ====
+incdir+.
div_pkg.sv
div_lane.sv
div_dispatch.sv
div_collect.sv
div_array.sv
tb_div_array.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_div_array -f div_array.f -o sim_tb_div_array
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

out=$(./obj_dir/sim_tb_div_array)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
        exit 0
fi
echo "pass message not found"
exit 1

// ==== tb_div_array.sv ====
`timescale 1ns/10ps
`include "div_config.svh"

module tb_div_array;

localparam int NUM_REQ = 400;
localparam int TIMEOUT = NUM_REQ * (`DIV_WIDTH + 6) + 200;     // worst lane latency plus slack

logic              clk;
logic              rst_n;
logic              in_valid;
div_pkg::operand_t in_a;
div_pkg::operand_t in_b;
logic              in_signed;
logic              busy;
logic              out_valid;
div_pkg::operand_t out_quo;
div_pkg::operand_t out_rem;
logic              out_dbz;

logic [15:0]       lfsr_state;
div_pkg::operand_t exp_quo_q [$];       // expected results in request order
div_pkg::operand_t exp_rem_q [$];
logic              exp_dbz_q [$];
int                sent;
int                received;
int                mismatch_errs;
int                other_errs;
int                cycles;

div_array i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_signed (in_signed),
        .busy      (busy),
        .out_valid (out_valid),
        .out_quo   (out_quo),
        .out_rem   (out_rem),
        .out_dbz   (out_dbz)
);

initial
begin
        clk = 1'b0;
        forever #50 clk = ~clk;
end

// galois form, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// one lfsr step per bit taken
task automatic draw_bits(input int n, output div_pkg::operand_t v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
                v          = {v[`DIV_WIDTH-2:0], lfsr_state[0]};
                lfsr_state = lfsr_next(lfsr_state);
        end
endtask

// biased toward the corner values
task automatic pick_operand(output div_pkg::operand_t v);
        div_pkg::operand_t cls;
        div_pkg::operand_t raw;
        div_pkg::operand_t sh;

        draw_bits(3, cls);
        case (cls[2:0])
        3'd0: v = '0;
        3'd1: v = '1;                                   // minus one
        3'd2: v = {1'b1, {(`DIV_WIDTH-1){1'b0}}};       // most negative
        3'd3:
        begin
                draw_bits(4, raw);
                v = raw;
        end
        3'd4:
        begin
                draw_bits(4, raw);
                v = '0 - raw;                           // small negative
        end
        default:
        begin
                draw_bits(`DIV_WIDTH, raw);
                draw_bits(5, sh);
                v = raw >> sh[4:0];     // uneven bit lengths
        end
        endcase
endtask

// risc-v div/divu/rem/remu
task automatic model_div(input div_pkg::operand_t a, input div_pkg::operand_t b,
                         input logic sgn, output div_pkg::operand_t q,
                         output div_pkg::operand_t r, output logic z);
        div_pkg::operand_t min_val;

        min_val = {1'b1, {(`DIV_WIDTH-1){1'b0}}};
        z = (b == '0);
        if (z)
        begin
                q = '1;
                r = a;
        end
        else if (sgn && a == min_val && b == '1)
        begin
                q = min_val;    // overflow case
                r = '0;
        end
        else if (sgn)
        begin
                q = $signed(a) / $signed(b);    // truncates toward zero
                r = $signed(a) % $signed(b);
        end
        else
        begin
                q = a / b;
                r = a % b;
        end
endtask

task automatic check_operand(input string name, input div_pkg::operand_t exp,
                             input div_pkg::operand_t act);
        if (act !== exp)
        begin
                $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
                mismatch_errs++;
        end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
                $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
                mismatch_errs++;
        end
endtask

task automatic check_output();
        if (out_valid)
        begin
                if (exp_quo_q.size() == 0)
                begin
                        $display("error at %0t: result came out with no request pending", $time);
                        other_errs++;
                end
                else
                begin
                        check_operand("out_quo", exp_quo_q.pop_front(), out_quo);
                        check_operand("out_rem", exp_rem_q.pop_front(), out_rem);
                        check_flag("out_dbz", exp_dbz_q.pop_front(), out_dbz);
                        received++;
                end
        end
endtask

// strobes also land while busy, those must be dropped
task automatic drive_cycle();
        div_pkg::operand_t gap;
        div_pkg::operand_t mode;
        div_pkg::operand_t a;
        div_pkg::operand_t b;
        div_pkg::operand_t q;
        div_pkg::operand_t r;
        logic              z;

        draw_bits(2, gap);
        if (gap[1:0] != 2'b00)
        begin
                draw_bits(1, mode);
                pick_operand(a);
                pick_operand(b);
                in_valid  = 1'b1;
                in_a      = a;
                in_b      = b;
                in_signed = mode[0];
                if (!busy)      // accepted
                begin
                        model_div(a, b, mode[0], q, r, z);
                        exp_quo_q.push_back(q);
                        exp_rem_q.push_back(r);
                        exp_dbz_q.push_back(z);
                        sent++;
                end
        end
        else
                in_valid = 1'b0;
endtask

task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d results seen",
                 mismatch_errs, other_errs, received, sent);
endtask

initial
begin
        in_valid      = 1'b0;
        in_a          = '0;
        in_b          = '0;
        in_signed     = 1'b0;
        rst_n         = 1'b0;
        lfsr_state    = 16'd33538;
        sent          = 0;
        received      = 0;
        mismatch_errs = 0;
        other_errs    = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("busy", 1'b0, busy);
        check_flag("out_valid", 1'b0, out_valid);

        while (sent < NUM_REQ)
        begin
                @(negedge clk);
                check_output();
                drive_cycle();
        end

        // drain the lanes
        while (exp_quo_q.size() != 0)
        begin
                @(negedge clk);
                in_valid = 1'b0;
                check_output();
        end

        // nothing more may come out
        repeat (40)
        begin
                @(negedge clk);
                in_valid = 1'b0;
                check_output();
        end

        report_counts();
        if (mismatch_errs + other_errs == 0)
                $display("STATUS: PASS");
        else
                $display("STATUS: FAIL");
        $finish;
end

initial
begin
        cycles = 0;
        while (cycles < TIMEOUT)
        begin
                @(posedge clk);
                cycles++;
        end
        $display("error: run stopped after %0d cycles with %0d requests still pending",
                 cycles, exp_quo_q.size());
        other_errs++;
        report_counts();
        $display("STATUS: FAIL");
        $finish;
end

endmodule

// ==== div_array.sv ====
`timescale 1ns/10ps
`include "div_config.svh"

module div_array (
        input  logic              clk,
        input  logic              rst_n,
        input  logic              in_valid,
        input  div_pkg::operand_t in_a,
        input  div_pkg::operand_t in_b,
        input  logic              in_signed,
        output logic              busy,
        output logic              out_valid,
        output div_pkg::operand_t out_quo,
        output div_pkg::operand_t out_rem,
        output logic              out_dbz
);

logic [`DIV_LANES-1:0] start;
logic [`DIV_LANES-1:0] lane_busy;
logic [`DIV_LANES-1:0] lane_held;
logic [`DIV_LANES-1:0] lane_dbz;
logic [`DIV_LANES-1:0] take;
div_pkg::operand_t     lane_quo [`DIV_LANES];
div_pkg::operand_t     lane_rem [`DIV_LANES];

div_dispatch i_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .lane_busy (lane_busy),
        .lane_held (lane_held),
        .start     (start),
        .busy      (busy)
);

// operands go to every lane, start picks the one that loads
for (genvar i = 0; i < `DIV_LANES; i++)
begin : g_lane
        div_lane i_lane (
                .clk       (clk),
                .rst_n     (rst_n),
                .start     (start[i]),
                .is_signed (in_signed),
                .a         (in_a),
                .b         (in_b),
                .take      (take[i]),
                .busy      (lane_busy[i]),
                .done      (),              // collector watches held
                .held      (lane_held[i]),
                .dbz       (lane_dbz[i]),
                .quo       (lane_quo[i]),
                .rem       (lane_rem[i])
        );
end

div_collect i_collect (
        .clk       (clk),
        .rst_n     (rst_n),
        .lane_held (lane_held),
        .lane_quo  (lane_quo),
        .lane_rem  (lane_rem),
        .lane_dbz  (lane_dbz),
        .take      (take),
        .out_valid (out_valid),
        .out_quo   (out_quo),
        .out_rem   (out_rem),
        .out_dbz   (out_dbz)
);

endmodule

// ==== div_collect.sv ====
`timescale 1ns/10ps
`include "div_config.svh"

module div_collect (
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic [`DIV_LANES-1:0] lane_held,
        input  div_pkg::operand_t     lane_quo [`DIV_LANES],
        input  div_pkg::operand_t     lane_rem [`DIV_LANES],
        input  logic [`DIV_LANES-1:0] lane_dbz,
        output logic [`DIV_LANES-1:0] take,       // clears held in the lane
        output logic                  out_valid,
        output div_pkg::operand_t     out_quo,
        output div_pkg::operand_t     out_rem,
        output logic                  out_dbz
);

div_pkg::lane_idx_t ptr;        // oldest outstanding request
logic               grab;

// skip a lane whose take is still in flight
assign grab = lane_held[ptr] && !take[ptr];

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                ptr       <= '0;
                take      <= '0;
                out_valid <= 1'b0;
        end
        else
        begin
                take      <= '0;
                out_valid <= grab;
                if (grab)
                begin
                        take[ptr] <= 1'b1;
                        ptr       <= div_pkg::next_lane(ptr);
                end
        end
end

// result registers, only meaningful with out_valid
always_ff @(posedge clk)
begin
        if (grab)
        begin
                out_quo <= lane_quo[ptr];
                out_rem <= lane_rem[ptr];
                out_dbz <= lane_dbz[ptr];
        end
end

endmodule

// ==== div_dispatch.sv ====
`timescale 1ns/10ps
`include "div_config.svh"

module div_dispatch (
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  in_valid,
        input  logic [`DIV_LANES-1:0] lane_busy,
        input  logic [`DIV_LANES-1:0] lane_held,    // result not yet collected
        output logic [`DIV_LANES-1:0] start,
        output logic                  busy
);

div_pkg::lane_idx_t ptr;                // next lane to receive a request
logic               ptr_free;
logic               accept;

// strict rotation, the collector relies on it
assign ptr_free = !lane_busy[ptr] && !lane_held[ptr];
assign accept   = in_valid && ptr_free;
assign busy     = !ptr_free;

always_comb
begin
        start      = '0;
        start[ptr] = accept;
end

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
                ptr <= '0;
        else if (accept)
                ptr <= div_pkg::next_lane(ptr);
end

endmodule

// ==== div_lane.sv ====
`timescale 1ns/10ps
`include "div_config.svh"

module div_lane (
        input  logic              clk,
        input  logic              rst_n,
        input  logic              start,
        input  logic              is_signed,
        input  div_pkg::operand_t a,            // dividend
        input  div_pkg::operand_t b,            // divisor
        input  logic              take,         // collector has the result
        output logic              busy,
        output logic              done,         // one cycle, result just landed
        output logic              held,
        output logic              dbz,
        output div_pkg::operand_t quo,
        output div_pkg::operand_t rem
);

// bit length of the dividend magnitude, zero for zero
function automatic div_pkg::iter_t bit_len(input div_pkg::operand_t v);
        div_pkg::iter_t len;

        len = '0;
        for (int i = 0; i < `DIV_WIDTH; i++)
        begin
                if (v[i])
                        len = div_pkg::iter_t'(i + 1);
        end
        return len;
endfunction

logic                load;
logic                b_zero;
logic                a_neg;
logic                b_neg;
div_pkg::operand_t   mag_a;
div_pkg::operand_t   mag_b;
div_pkg::iter_t      len_a;

logic [`DIV_WIDTH:0] acc;               // partial remainder, one bit wider
logic [`DIV_WIDTH:0] reduced;
logic [`DIV_WIDTH:0] acc_next;
logic [`DIV_WIDTH:0] dvd;               // next dividend bit sits at the top
div_pkg::operand_t   dvs;
div_pkg::operand_t   q_work;
logic                ge;
div_pkg::iter_t      cnt;
div_pkg::iter_t      limit;
logic                neg_q;
logic                neg_r;

assign load   = start && !busy && !held;    // stray strobes are dropped
assign b_zero = (b == '0);

// strip the signs before the loop
always_comb
begin
        a_neg = is_signed && a[`DIV_WIDTH-1];
        b_neg = is_signed && b[`DIV_WIDTH-1];
        mag_a = a_neg ? -a : a;
        mag_b = b_neg ? -b : b;
        len_a = bit_len(mag_a);
end

// one restoring shift-subtract step
always_comb
begin
        ge       = (acc >= {1'b0, dvs});
        reduced  = ge ? acc - {1'b0, dvs} : acc;
        acc_next = {reduced[`DIV_WIDTH-1:0], dvd[`DIV_WIDTH]};
end

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                busy <= 1'b0;
                done <= 1'b0;
                held <= 1'b0;
                dbz  <= 1'b0;
                cnt  <= '0;
        end
        else
        begin
                done <= 1'b0;
                if (take)
                        held <= 1'b0;

                if (load)
                begin
                        cnt <= '0;
                        if (b_zero)     // no loop, answer is fixed
                        begin
                                dbz  <= 1'b1;
                                done <= 1'b1;
                                held <= 1'b1;
                        end
                        else
                        begin
                                dbz  <= 1'b0;
                                busy <= 1'b1;
                        end
                end
                else if (busy)
                begin
                        if (cnt == limit)
                        begin
                                busy <= 1'b0;
                                done <= 1'b1;
                                held <= 1'b1;
                        end
                        else
                                cnt <= cnt + 1'b1;
                end
        end
end

always_ff @(posedge clk)
begin
        if (load)
        begin
                if (b_zero)
                begin
                        quo <= '1;
                        rem <= a;       // raw dividend, sign untouched
                end
                else
                begin
                        // top set bit lands just under the shift-out position
                        dvd    <= {1'b0, mag_a} << (`DIV_WIDTH - len_a);
                        dvs    <= mag_b;
                        acc    <= '0;
                        q_work <= '0;
                        limit  <= len_a + 2'd2;
                        neg_q  <= a_neg ^ b_neg;
                        neg_r  <= a_neg;        // remainder follows the dividend
                end
        end
        else if (busy)
        begin
                if (cnt == limit)
                begin
                        // last step shifted a spare zero into acc
                        quo <= neg_q ? -q_work : q_work;
                        rem <= neg_r ? -acc[`DIV_WIDTH:1] : acc[`DIV_WIDTH:1];
                end
                else
                begin
                        acc    <= acc_next;
                        q_work <= {q_work[`DIV_WIDTH-2:0], ge};
                        dvd    <= dvd << 1;
                end
        end
end

endmodule

// ==== div_pkg.sv ====
`include "div_config.svh"

package div_pkg;

        // a single lane still needs one index bit
        localparam int LANE_IDX_W = (`DIV_LANES > 1) ? $clog2(`DIV_LANES) : 1;

        typedef logic [`DIV_WIDTH-1:0] operand_t;     // dividend, divisor, quotient, remainder
        typedef logic [LANE_IDX_W-1:0] lane_idx_t;
        typedef logic [`DIV_CNT_W-1:0] iter_t;        // step counter and step limit

        // round-robin successor, same order for dispatcher and collector
        function automatic lane_idx_t next_lane(input lane_idx_t idx);
                if (idx == lane_idx_t'(`DIV_LANES - 1))
                        return '0;
                return idx + 1'b1;
        endfunction

endpackage

// ==== div_config.svh ====
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// operand width in bits
`define DIV_WIDTH 32

// number of iterative lanes behind the dispatcher
`define DIV_LANES 4

// step counter, must hold DIV_WIDTH+2
`define DIV_CNT_W 6

`endif
